//--- Bender.yml
package:
  name: mono_pix
  description: "Digital readout periphery of a monolithic pixel sensor"

sources:
  - design/monoPixPkg.sv
  - design/hitLinkIf.sv
  - design/confShiftReg.sv
  - design/hitStamper.sv
  - design/hitBuffer.sv
  - design/frameSerializer.sv
  - design/monoPixTop.sv

  - target: test
    files:
      - tb/monoPixChecker.sv
      - tb/monoPixTb.sv

//--- design/confShiftReg.sv
`timescale 1ns/10ps
`default_nettype none

module confShiftReg (
    input  wire logic             ClkBx,
    input  wire logic             reset_ff,
    input  wire logic             DefConf,
    input  wire logic             ShiftConf,
    input  wire logic             LdConf,
    input  wire logic             SiConf,
    output logic                  SoConf,
    output monoPixPkg::confT      Conf
);
    import monoPixPkg::*;

    confT shadowReg; // Serial side, Conf is the copy the readout uses

    assign SoConf = shadowReg[ConfBits-1];

    always_ff @(posedge ClkBx) begin
        if (reset_ff || DefConf) begin
            shadowReg <= DefaultConf;
            Conf      <= DefaultConf;
        end else begin
            if (ShiftConf) begin
                shadowReg <= {shadowReg[ConfBits-2:0], SiConf}; // New bit enters at LSB
            end
            if (LdConf) begin
                Conf <= shadowReg;
            end
        end
    end

    // Loading in the middle of a shift would capture a half-written word
    shiftLoadExclusive: assert property (
        @(posedge ClkBx) disable iff (reset_ff)
        !(ShiftConf && LdConf)
    ) else $error("ShiftConf and LdConf high in the same cycle");

endmodule

`default_nettype wire

//--- design/frameSerializer.sv
`timescale 1ns/10ps
`default_nettype none

module frameSerializer (
    input  wire logic ClkBx,
    input  wire logic reset_ff,
    input  wire logic Read,
    hitLinkIf.rcv     In,
    output logic      Token,
    output logic      DataOut,
    output logic      FrameSync
);
    import monoPixPkg::*;

    localparam int IdxBits = $clog2(WordBits);

    serStateT            state;
    hitWordT             wordReg;
    logic [IdxBits-1:0]  bitIdx;   // Bit currently on DataOut
    logic                lastBit;

    assign lastBit = (state == SerShift) && Read && (bitIdx == '0);

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            state  <= SerIdle;
            bitIdx <= '0;
        end else begin
            case (state)
                SerIdle: begin
                    if (In.Valid) begin
                        state  <= SerShift;
                        bitIdx <= IdxBits'(WordBits - 1); // MSB first
                    end
                end
                SerShift: begin
                    if (lastBit) begin
                        state <= SerIdle;
                    end else if (Read) begin
                        bitIdx <= bitIdx - 1'b1;
                    end
                end
                default: state <= SerIdle;
            endcase
        end
    end

    always_ff @(posedge ClkBx) begin
        if (state == SerIdle && In.Valid) begin
            wordReg <= '{Col: In.Col, Row: In.Row, Bcid: In.Bcid};
        end
    end

    assign Token     = state == SerShift;
    assign DataOut   = (state == SerShift) && wordReg[bitIdx];
    assign FrameSync = (state == SerShift) && (bitIdx == IdxBits'(WordBits - 1));
    assign In.Credit = lastBit; // Holding register free again

    // Buffer may only send after the credit came back
    validOnlyInIdle: assert property (
        @(posedge ClkBx) disable iff (reset_ff)
        In.Valid |-> state == SerIdle
    ) else $error("Word delivered while serializer busy");

endmodule

`default_nettype wire

//--- design/hitBuffer.sv
`timescale 1ns/10ps
`default_nettype none

module hitBuffer #(
    parameter int BufDepth = 8
) (
    input  wire logic ClkBx,
    input  wire logic reset_ff,
    hitLinkIf.rcv     In,
    hitLinkIf.snd     Out
);
    import monoPixPkg::*;

    localparam int PtrBits = $clog2(BufDepth);

    hitWordT            mem [BufDepth];
    logic [PtrBits:0]   wrPtr; // Extra MSB tells full from empty
    logic [PtrBits:0]   rdPtr;
    logic               dnCredit; // Serializer holding register is free
    logic               empty;
    logic               full;
    logic               pop;

    assign empty = wrPtr == rdPtr;
    assign full  = (wrPtr[PtrBits] != rdPtr[PtrBits])
                   && (wrPtr[PtrBits-1:0] == rdPtr[PtrBits-1:0]);
    assign pop   = !empty && dnCredit;

    always_ff @(posedge ClkBx) begin
        if (In.Valid) begin
            mem[wrPtr[PtrBits-1:0]] <= '{Col: In.Col, Row: In.Row, Bcid: In.Bcid};
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            dnCredit  <= 1'b1;
            Out.Valid <= 1'b0;
            In.Credit <= 1'b0;
        end else begin
            if (In.Valid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Spent on pop, given back when the last bit leaves the serializer
            dnCredit  <= (dnCredit && !pop) || Out.Credit;
            Out.Valid <= pop;
            In.Credit <= pop; // Slot freed, one credit upstream
        end
    end

    always_ff @(posedge ClkBx) begin
        if (pop) begin
            Out.Col  <= mem[rdPtr[PtrBits-1:0]].Col;
            Out.Row  <= mem[rdPtr[PtrBits-1:0]].Row;
            Out.Bcid <= mem[rdPtr[PtrBits-1:0]].Bcid;
        end
    end

    // Stamper credit accounting has to keep the FIFO from overflowing
    noPushWhenFull: assert property (
        @(posedge ClkBx) disable iff (reset_ff)
        In.Valid |-> !full
    ) else $error("Hit pushed into full buffer");

endmodule

`default_nettype wire

//--- design/hitLinkIf.sv
`timescale 1ns/10ps
`default_nettype none

// One hit word per Valid cycle, receiver hands back one credit per freed slot
interface hitLinkIf;
    import monoPixPkg::*;

    logic                Valid;
    logic [ColBits-1:0]  Col;
    logic [RowBits-1:0]  Row;
    logic [BcidBits-1:0] Bcid;
    logic                Credit; // Single cycle pulse from receiver

    modport snd (output Valid, Col, Row, Bcid, input Credit);
    modport rcv (input Valid, Col, Row, Bcid, output Credit);

endinterface

`default_nettype wire

//--- design/hitStamper.sv
`timescale 1ns/10ps
`default_nettype none

module hitStamper #(
    parameter int BufDepth = 8
) (
    input  wire logic                         ClkBx,
    input  wire logic                         reset_ff,
    input  wire logic                         ResetBcid,
    input  wire logic                         HitValid,
    input  wire logic [monoPixPkg::ColBits-1:0] HitCol,
    input  wire logic [monoPixPkg::RowBits-1:0] HitRow,
    input  wire monoPixPkg::confT             Conf,
    hitLinkIf.snd                             Out
);
    import monoPixPkg::*;

    localparam int CntBits = $clog2(BufDepth + 1);

    logic [BcidBits-1:0] bcidBin;
    logic [BcidBits-1:0] bcidGray;
    logic [CntBits-1:0]  creditCnt; // Free slots in the buffer
    logic                colInRange;
    logic                sendHit;

    always_ff @(posedge ClkBx) begin
        if (reset_ff || ResetBcid) begin
            bcidBin <= '0;
        end else begin
            bcidBin <= bcidBin + 1'b1;
        end
    end

    assign bcidGray = bcidBin ^ (bcidBin >> 1);

    // Addresses above the last column never pass the filter
    assign colInRange = HitCol < ColBits'(NumCols);
    assign sendHit    = HitValid && Conf.Enable && colInRange && Conf.ColEnable[HitCol]
                        && (creditCnt != '0);

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            Out.Valid <= 1'b0;
            creditCnt <= CntBits'(BufDepth);
        end else begin
            Out.Valid <= sendHit;
            creditCnt <= creditCnt - CntBits'(sendHit) + CntBits'(Out.Credit);
        end
    end

    always_ff @(posedge ClkBx) begin
        if (sendHit) begin
            Out.Col  <= Conf.EnTestPattern ? TestPatternCol : HitCol;
            Out.Row  <= Conf.EnTestPattern ? TestPatternRow : HitRow;
            Out.Bcid <= bcidGray; // Stamp of the sampling edge
        end
    end

    // Buffer must never return more credits than it has slots
    creditBound: assert property (
        @(posedge ClkBx) disable iff (reset_ff)
        creditCnt <= CntBits'(BufDepth)
    ) else $error("Stamper credit count above BufDepth");

endmodule

`default_nettype wire

//--- design/monoPixPkg.sv
`default_nettype none

package monoPixPkg;

    localparam int NumCols  = 48;
    localparam int ColBits  = 6;
    localparam int RowBits  = 8;
    localparam int BcidBits = 6;
    localparam int WordBits = ColBits + RowBits + BcidBits; // 20 bit hit frame

    // Readout configuration, Enable sits at the MSB of the shift chain
    typedef struct packed {
        logic               Enable;
        logic               EnTestPattern;
        logic [NumCols-1:0] ColEnable;
    } confT;

    localparam int ConfBits = $bits(confT);

    localparam confT DefaultConf = '{
        Enable:        1'b1,
        EnTestPattern: 1'b0,
        ColEnable:     {NumCols{1'b1}}
    };

    // Column is sent first
    typedef struct packed {
        logic [ColBits-1:0]  Col;
        logic [RowBits-1:0]  Row;
        logic [BcidBits-1:0] Bcid;
    } hitWordT;

    localparam logic [ColBits-1:0] TestPatternCol = 6'h2A;
    localparam logic [RowBits-1:0] TestPatternRow = 8'hA5;

    typedef enum logic {
        SerIdle,
        SerShift
    } serStateT;

endpackage

`default_nettype wire

//--- design/monoPixTop.sv
`timescale 1ns/10ps
`default_nettype none

module monoPixTop #(
    parameter int BufDepth = 8
) (
    input  wire logic                           ClkBx,
    input  wire logic                           reset_ff,
    input  wire logic                           DefConf,
    input  wire logic                           ShiftConf,
    input  wire logic                           LdConf,
    input  wire logic                           SiConf,
    output logic                                SoConf,
    input  wire logic                           HitValid,
    input  wire logic [monoPixPkg::ColBits-1:0] HitCol,
    input  wire logic [monoPixPkg::RowBits-1:0] HitRow,
    input  wire logic                           ResetBcid,
    input  wire logic                           Read,
    output logic                                Token,
    output logic                                DataOut,
    output logic                                FrameSync
);
    import monoPixPkg::*;

    confT conf;

    hitLinkIf stampLink ();
    hitLinkIf serLink ();

    confShiftReg i_confShiftReg (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .DefConf   (DefConf),
        .ShiftConf (ShiftConf),
        .LdConf    (LdConf),
        .SiConf    (SiConf),
        .SoConf    (SoConf),
        .Conf      (conf)
    );

    hitStamper #(.BufDepth(BufDepth)) i_hitStamper (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ResetBcid (ResetBcid),
        .HitValid  (HitValid),
        .HitCol    (HitCol),
        .HitRow    (HitRow),
        .Conf      (conf),
        .Out       (stampLink.snd)
    );

    hitBuffer #(.BufDepth(BufDepth)) i_hitBuffer (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .In       (stampLink.rcv),
        .Out      (serLink.snd)
    );

    frameSerializer i_frameSerializer (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .Read      (Read),
        .In        (serLink.rcv),
        .Token     (Token),
        .DataOut   (DataOut),
        .FrameSync (FrameSync)
    );

endmodule

`default_nettype wire

//--- sources.f
design/monoPixPkg.sv
design/hitLinkIf.sv
design/confShiftReg.sv
design/hitStamper.sv
design/hitBuffer.sv
design/frameSerializer.sv
design/monoPixTop.sv
tb/monoPixChecker.sv
tb/monoPixTb.sv

//--- tb/monoPixChecker.sv
`timescale 1ns/10ps
`default_nettype none

module monoPixChecker #(
    parameter int BufDepth = 8
) (
    input  wire logic                           ClkBx,
    input  wire logic                           reset_ff,
    input  wire logic                           DefConf,
    input  wire logic                           ShiftConf,
    input  wire logic                           LdConf,
    input  wire logic                           SiConf,
    input  wire logic                           SoConf,
    input  wire logic                           HitValid,
    input  wire logic [monoPixPkg::ColBits-1:0] HitCol,
    input  wire logic [monoPixPkg::RowBits-1:0] HitRow,
    input  wire logic                           ResetBcid,
    input  wire logic                           Read,
    input  wire logic                           Token,
    input  wire logic                           DataOut,
    input  wire logic                           FrameSync,
    input  wire logic                           EndOfTest,
    output int                                  errorCount,
    output int                                  frameCount
);
    import monoPixPkg::*;

    confT                shadowConf;
    confT                activeConf;
    logic [BcidBits-1:0] bcidCnt;   // Model BCID in binary
    hitWordT             expQ [$];
    hitWordT             expWord;
    logic [WordBits-1:0] frameBits;
    int                  bitCnt;
    int                  occupancy; // Accepted words not yet fully shifted out
    logic                inFrame;
    logic                endSeen;

    // Expected frame of one hit and whether it passes the filter
    function automatic logic expectHit(
        input  logic [ColBits-1:0]  col,
        input  logic [RowBits-1:0]  row,
        input  logic [BcidBits-1:0] bcid,
        input  confT                conf,
        output hitWordT             word
    );
        // Gray code flips a single bit per count
        word.Bcid[BcidBits-1] = bcid[BcidBits-1];
        for (int i = BcidBits - 2; i >= 0; i--) begin
            word.Bcid[i] = bcid[i + 1] ^ bcid[i];
        end
        if (conf.EnTestPattern) begin
            word.Col = TestPatternCol;
            word.Row = TestPatternRow;
        end else begin
            word.Col = col;
            word.Row = row;
        end
        return conf.Enable && (col < NumCols) && conf.ColEnable[col];
    endfunction

    initial begin
        errorCount = 0;
        frameCount = 0;
        endSeen    = 1'b0;
    end

    always @(posedge ClkBx) begin
        if (reset_ff) begin
            shadowConf = DefaultConf;
            activeConf = DefaultConf;
            bcidCnt    = '0;
            occupancy  = 0;
            inFrame    = 1'b0;
            expQ.delete();
        end else begin
            if (SoConf !== shadowConf[ConfBits-1]) begin
                errorCount++;
                $display("Mismatch at %0t: SoConf expected %b, received %b",
                         $time, shadowConf[ConfBits-1], SoConf);
            end
            if (FrameSync && !Token) begin
                errorCount++;
                $display("FrameSync high at %0t while no frame is being sent", $time);
            end
            // Hit counts only while there is room for it
            if (HitValid && occupancy < BufDepth + 1
                && expectHit(HitCol, HitRow, bcidCnt, activeConf, expWord)) begin
                expQ.push_back(expWord);
                occupancy++;
            end
            if (Token && Read) begin
                if (FrameSync) begin
                    inFrame = 1'b1;
                    bitCnt  = 0;
                end
                if (!inFrame) begin
                    errorCount++;
                    $display("Data bit shifted at %0t without a frame start", $time);
                end else begin
                    frameBits = {frameBits[WordBits-2:0], DataOut}; // MSB arrives first
                    bitCnt++;
                end
                if (inFrame && bitCnt == WordBits) begin
                    inFrame = 1'b0;
                    frameCount++;
                    occupancy--;
                    if (expQ.size() == 0) begin
                        errorCount++;
                        $display("Frame %h at %0t arrived with no hit expected",
                                 frameBits, $time);
                    end else begin
                        expWord = expQ.pop_front();
                        if (frameBits !== expWord) begin
                            errorCount++;
                            $display("Mismatch at %0t: expected %h, received %h",
                                     $time, expWord, frameBits);
                        end
                    end
                end
            end
            if (DefConf) begin
                shadowConf = DefaultConf;
                activeConf = DefaultConf;
            end else begin
                if (LdConf) begin
                    activeConf = shadowConf; // Copy of the shadow before this edge
                end
                if (ShiftConf) begin
                    shadowConf = {shadowConf[ConfBits-2:0], SiConf};
                end
            end
            bcidCnt = ResetBcid ? '0 : bcidCnt + 1'b1;
            if (EndOfTest && !endSeen) begin
                endSeen = 1'b1;
                if (expQ.size() != 0) begin
                    errorCount++;
                    $display("Run ended with %0d expected frames never received",
                             expQ.size());
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/monoPixTb.sv
`timescale 1ns/10ps
`default_nettype none

module monoPixTb;
    import monoPixPkg::*;

    localparam int BufDepth      = 8;
    localparam int TimeoutCycles = 20000; // About 300 hits plus margin

    logic               ClkBx = 1'b0;
    logic               reset_ff;
    logic               DefConf;
    logic               ShiftConf;
    logic               LdConf;
    logic               SiConf;
    logic               SoConf;
    logic               HitValid;
    logic [ColBits-1:0] HitCol;
    logic [RowBits-1:0] HitRow;
    logic               ResetBcid;
    logic               Read;
    logic               Token;
    logic               DataOut;
    logic               FrameSync;
    logic               EndOfTest;
    int                 errorCount;
    int                 frameCount;
    int                 cycleCnt = 0;

    monoPixTop #(.BufDepth(BufDepth)) i_monoPixTop (.*);

    monoPixChecker #(.BufDepth(BufDepth)) i_monoPixChecker (.*);

    always #10 ClkBx = ~ClkBx;

    always @(posedge ClkBx) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= TimeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic waitCycles(input int n);
        repeat (n) @(posedge ClkBx);
    endtask

    // One hit, valid for exactly one sampling edge
    task automatic sendHit(input logic [ColBits-1:0] col, input logic [RowBits-1:0] row);
        @(posedge ClkBx);
        HitValid <= 1'b1;
        HitCol   <= col;
        HitRow   <= row;
        @(posedge ClkBx);
        HitValid <= 1'b0;
    endtask

    task automatic randomHits(input int n, input int minGap, input int maxGap,
                              input logic randRead);
        int gap;
        for (int i = 0; i < n; i++) begin
            sendHit(ColBits'($urandom % NumCols), RowBits'($urandom));
            gap = minGap + $urandom % (maxGap - minGap + 1);
            repeat (gap) begin
                @(posedge ClkBx);
                if (randRead) begin
                    Read <= ($urandom % 4) != 0; // Read low about a quarter of the time
                end
            end
        end
        Read <= 1'b1;
    endtask

    task automatic shiftConfig(input confT conf);
        for (int i = ConfBits - 1; i >= 0; i--) begin
            @(posedge ClkBx);
            ShiftConf <= 1'b1;
            SiConf    <= conf[i];
        end
        @(posedge ClkBx);
        ShiftConf <= 1'b0;
        LdConf    <= 1'b1;
        @(posedge ClkBx);
        LdConf <= 1'b0;
    endtask

    task automatic pulseDefaultConf();
        @(posedge ClkBx);
        DefConf <= 1'b1;
        @(posedge ClkBx);
        DefConf <= 1'b0;
    endtask

    task automatic pulseBcidReset();
        @(posedge ClkBx);
        ResetBcid <= 1'b1;
        @(posedge ClkBx);
        ResetBcid <= 1'b0;
    endtask

    // Serializer idle long enough that nothing is left in the buffer
    task automatic drainPipeline();
        int idle;
        idle = 0;
        while (idle < 8) begin
            @(posedge ClkBx);
            idle = Token ? 0 : idle + 1;
        end
    endtask

    initial begin
        confT conf;
        int   seed;
        seed = 32'h5005;
        void'($urandom(seed));
        reset_ff  <= 1'b1;
        DefConf   <= 1'b0;
        ShiftConf <= 1'b0;
        LdConf    <= 1'b0;
        SiConf    <= 1'b0;
        HitValid  <= 1'b0;
        HitCol    <= '0;
        HitRow    <= '0;
        ResetBcid <= 1'b0;
        Read      <= 1'b1;
        EndOfTest <= 1'b0;
        waitCycles(16);
        reset_ff <= 1'b0;

        randomHits(60, 25, 45, 1'b0); // Default configuration
        drainPipeline();

        Read <= 1'b0; // Overflow burst, only BufDepth+1 words fit
        repeat (14) sendHit(ColBits'($urandom % NumCols), RowBits'($urandom));
        waitCycles(10);
        Read <= 1'b1;
        drainPipeline();

        conf           = DefaultConf;
        conf.ColEnable = NumCols'({$urandom, $urandom}); // Roughly half the columns off
        shiftConfig(conf);
        randomHits(60, 25, 45, 1'b0);
        drainPipeline();

        conf               = DefaultConf;
        conf.EnTestPattern = 1'b1;
        shiftConfig(conf);
        randomHits(25, 25, 45, 1'b0);
        conf.Enable = 1'b0;
        shiftConfig(conf);
        randomHits(15, 25, 45, 1'b0);
        drainPipeline();
        pulseDefaultConf();

        randomHits(60, 40, 70, 1'b1); // Read gaps
        drainPipeline();

        randomHits(10, 25, 45, 1'b0);
        pulseBcidReset();
        sendHit(ColBits'($urandom % NumCols), RowBits'($urandom));
        randomHits(10, 25, 45, 1'b0);
        drainPipeline();

        EndOfTest <= 1'b1;
        waitCycles(1);
        @(negedge ClkBx);
        $display("Frames checked: %0d, errors: %0d", frameCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
